// File: build.f
+incdir+testbench
source/rsa_pkg.sv
source/rsa_mont_mul.sv
source/rsa_mod_prep.sv
source/rsa_exp_ctrl.sv
source/rsa_axil_regs.sv
source/rsa_top.sv
testbench/tb_rsa_top.sv

// File: source/rsa_axil_regs.sv
`timescale 1ns/1ns

module rsa_axil_regs
    import rsa_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  axil_req_t        i_axil,
    output axil_rsp_t        o_axil,
    output rsa_job_t         o_job,
    output logic             o_start,
    input  logic             i_busy,
    input  logic             i_done,
    input  logic [KEY_W-1:0] i_result
);

    addr_dec_t         wr_dec;
    addr_dec_t         rd_dec;
    logic              wr_acc;
    logic              rd_acc;
    logic              wr_ok;
    logic              rd_ok;
    logic              eng_busy;
    logic [AXI_DW-1:0] rd_word;

    logic [AXI_DW-1:0] n_q [KEY_WORDS];
    logic [AXI_DW-1:0] e_q [KEY_WORDS];
    logic [AXI_DW-1:0] y_q [KEY_WORDS];
    logic [KEY_W-1:0]  result_q;
    logic              start_q;
    logic              done_q;
    logic              bvalid_q;
    logic [1:0]        bresp_q;
    logic              rvalid_q;
    logic [1:0]        rresp_q;
    logic [AXI_DW-1:0] rdata_q;

    function automatic addr_dec_t decode(input logic [AXI_AW-1:0] addr);
        addr_dec_t d;
        d.ctrl   = addr[AXI_AW-1:2] == ADDR_CTRL[AXI_AW-1:2];
        d.status = addr[AXI_AW-1:2] == ADDR_STATUS[AXI_AW-1:2];
        d.n      = addr[AXI_AW-1:WIDX_W+2] == ADDR_N[AXI_AW-1:WIDX_W+2];
        d.e      = addr[AXI_AW-1:WIDX_W+2] == ADDR_E[AXI_AW-1:WIDX_W+2];
        d.y      = addr[AXI_AW-1:WIDX_W+2] == ADDR_Y[AXI_AW-1:WIDX_W+2];
        d.res    = addr[AXI_AW-1:WIDX_W+2] == ADDR_RES[AXI_AW-1:WIDX_W+2];
        d.idx    = addr[WIDX_W+1:2];
        return d;
    endfunction

    function automatic logic [AXI_DW-1:0] merge(
        input logic [AXI_DW-1:0]   old_w,
        input logic [AXI_DW-1:0]   new_w,
        input logic [AXI_DW/8-1:0] strb
    );
        logic [AXI_DW-1:0] w;
        w = old_w;
        for (int b = 0; b < AXI_DW / 8; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    assign wr_dec   = decode(i_axil.awaddr);
    assign rd_dec   = decode(i_axil.araddr);
    // AW and W are taken together, never with a response pending.
    assign wr_acc   = i_axil.awvalid & i_axil.wvalid & ~bvalid_q;
    assign rd_acc   = i_axil.arvalid & ~rvalid_q;
    assign wr_ok    = wr_dec.ctrl | wr_dec.n | wr_dec.e | wr_dec.y;
    assign eng_busy = i_busy | start_q;
    assign o_start  = start_q;

    always_comb begin
        for (int k = 0; k < KEY_WORDS; k++) begin
            o_job.n[k*AXI_DW +: AXI_DW] = n_q[k];
            o_job.e[k*AXI_DW +: AXI_DW] = e_q[k];
            o_job.y[k*AXI_DW +: AXI_DW] = y_q[k];
        end
    end

    // ==================
    // Read mux
    // ==================
    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        if (rd_dec.status) begin
            rd_word = {{(AXI_DW-2){1'b0}}, done_q, eng_busy};
        end else if (rd_dec.n) begin
            rd_word = n_q[rd_dec.idx];
        end else if (rd_dec.e) begin
            rd_word = e_q[rd_dec.idx];
        end else if (rd_dec.y) begin
            rd_word = y_q[rd_dec.idx];
        end else if (rd_dec.res) begin
            rd_word = result_q[rd_dec.idx*AXI_DW +: AXI_DW];
        end else begin
            rd_ok = 1'b0;
        end
    end

    always_comb begin
        o_axil.awready = wr_acc;
        o_axil.wready  = wr_acc;
        o_axil.bvalid  = bvalid_q;
        o_axil.bresp   = bresp_q;
        o_axil.arready = rd_acc;
        o_axil.rvalid  = rvalid_q;
        o_axil.rdata   = rdata_q;
        o_axil.rresp   = rresp_q;
    end

    // ==================
    // Handshake and status
    // ==================
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
            rvalid_q <= 1'b0;
            rresp_q  <= RESP_OKAY;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            start_q <= 1'b0;
            if (wr_acc) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                if (wr_dec.ctrl && !eng_busy && i_axil.wstrb[0] && i_axil.wdata[0]) begin
                    start_q <= 1'b1;
                end
            end else if (i_axil.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_acc) begin
                rvalid_q <= 1'b1;
                rresp_q  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (i_axil.rready) begin
                rvalid_q <= 1'b0;
            end
            if (start_q) begin
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q   <= 1'b1;
                result_q <= i_result;
            end
        end
    end

    // Operand arrays and read data.
    always_ff @(posedge i_clk) begin
        if (rd_acc) begin
            rdata_q <= rd_word;
        end
        if (wr_acc && !eng_busy) begin
            if (wr_dec.n) begin
                n_q[wr_dec.idx] <= merge(n_q[wr_dec.idx], i_axil.wdata, i_axil.wstrb);
            end
            if (wr_dec.e) begin
                e_q[wr_dec.idx] <= merge(e_q[wr_dec.idx], i_axil.wdata, i_axil.wstrb);
            end
            if (wr_dec.y) begin
                y_q[wr_dec.idx] <= merge(y_q[wr_dec.idx], i_axil.wdata, i_axil.wstrb);
            end
        end
    end

endmodule

// File: source/rsa_exp_ctrl.sv
`timescale 1ns/1ns

module rsa_exp_ctrl
    import rsa_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  rsa_job_t         i_job,
    output logic             o_busy,
    output logic             o_done,
    output logic [KEY_W-1:0] o_result
);

    logic [1:0]       state_q;
    logic [CNT_W-1:0] bit_q;
    logic             busy_q;
    logic             done_q;
    logic             prep_start_q;
    logic             mul_start_q;
    logic [KEY_W-1:0] t_q;
    logic [KEY_W-1:0] m_q;
    logic [KEY_W-1:0] result_q;

    logic [KEY_W-1:0] prep_t;
    logic             prep_done;
    logic [KEY_W-1:0] sqr_m;
    logic             sqr_done;
    logic [KEY_W-1:0] mul_m;
    logic             mul_done;
    logic             step_done;
    logic             e_bit;

    assign o_busy    = busy_q;
    assign o_done    = done_q;
    assign o_result  = result_q;
    // Both multipliers have the same latency.
    assign step_done = sqr_done & mul_done;
    assign e_bit     = i_job.e[bit_q[CNT_W-2:0]];

    // ==================
    // Children
    // ==================
    rsa_mod_prep u_mod_prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start_q),
        .i_n     (i_job.n),
        .i_y     (i_job.y),
        .o_t     (prep_t),
        .o_done  (prep_done)
    );

    // m stays in the normal domain, t = y^(2^k) * R mod N.
    rsa_mont_mul u_mont_mul (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start_q),
        .i_n     (i_job.n),
        .i_a     (m_q),
        .i_b     (t_q),
        .o_m     (mul_m),
        .o_done  (mul_done)
    );

    rsa_mont_mul u_mont_sqr (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start_q),
        .i_n     (i_job.n),
        .i_a     (t_q),
        .i_b     (t_q),
        .o_m     (sqr_m),
        .o_done  (sqr_done)
    );

    // ==================
    // Control
    // ==================
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q      <= EX_IDLE;
            bit_q        <= '0;
            busy_q       <= 1'b0;
            done_q       <= 1'b0;
            prep_start_q <= 1'b0;
            mul_start_q  <= 1'b0;
        end else begin
            done_q       <= 1'b0;
            prep_start_q <= 1'b0;
            mul_start_q  <= 1'b0;
            case (state_q)
                EX_IDLE: begin
                    if (i_start) begin
                        state_q      <= EX_PREP;
                        busy_q       <= 1'b1;
                        prep_start_q <= 1'b1;
                    end
                end
                EX_PREP: begin
                    if (prep_done) begin
                        state_q     <= EX_LOOP;
                        bit_q       <= '0;
                        mul_start_q <= 1'b1;
                    end
                end
                EX_LOOP: begin
                    if (step_done) begin
                        if (bit_q == CNT_W'(KEY_W - 1)) begin
                            state_q <= EX_FIN;
                        end else begin
                            bit_q       <= bit_q + 1'b1;
                            mul_start_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= EX_IDLE;
                    busy_q  <= 1'b0;
                    done_q  <= 1'b1;
                end
            endcase
        end
    end

    // Operand registers, updated only between multiplier runs.
    always_ff @(posedge i_clk) begin
        if (state_q == EX_PREP && prep_done) begin
            t_q <= prep_t;
            m_q <= KEY_W'(1);
        end else if (state_q == EX_LOOP && step_done) begin
            t_q <= sqr_m;
            if (e_bit) begin
                m_q <= mul_m;
            end
        end else if (state_q == EX_FIN) begin
            result_q <= m_q;
        end
    end

endmodule

// File: source/rsa_mod_prep.sv
`timescale 1ns/1ns

module rsa_mod_prep
    import rsa_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic [KEY_W-1:0] i_n,
    input  logic [KEY_W-1:0] i_y,
    output logic [KEY_W-1:0] o_t,
    output logic             o_done
);

    logic [1:0]       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             done_q;
    logic [KEY_W:0]   work_q;
    logic [KEY_W:0]   dbl;
    logic [KEY_W:0]   work_next;
    logic [KEY_W-1:0] t_q;

    assign o_t    = t_q;
    assign o_done = done_q;

    // Double, then bring back below N.
    always_comb begin
        dbl = {work_q[KEY_W-1:0], 1'b0};
        if (dbl >= {1'b0, i_n}) begin
            work_next = dbl - {1'b0, i_n};
        end else begin
            work_next = dbl;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= PR_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                PR_IDLE: begin
                    if (i_start) begin
                        state_q <= PR_LOAD;
                    end
                end
                PR_LOAD: begin
                    state_q <= PR_RUN;
                    cnt_q   <= '0;
                end
                PR_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(KEY_W - 1)) begin
                        state_q <= PR_OUT;
                    end
                end
                default: begin
                    state_q <= PR_IDLE;
                    done_q  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == PR_LOAD) begin
            work_q <= {1'b0, i_y};
        end else if (state_q == PR_RUN) begin
            work_q <= work_next;
        end else if (state_q == PR_OUT) begin
            t_q <= work_q[KEY_W-1:0];
        end
    end

endmodule

// File: source/rsa_mont_mul.sv
`timescale 1ns/1ns

module rsa_mont_mul
    import rsa_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic [KEY_W-1:0] i_n,
    input  logic [KEY_W-1:0] i_a,
    input  logic [KEY_W-1:0] i_b,
    output logic [KEY_W-1:0] o_m,
    output logic             o_done
);

    logic [1:0]       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             done_q;
    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] sum;
    logic [ACC_W-1:0] acc_next;
    logic [KEY_W-1:0] m_q;

    assign o_m    = m_q;
    assign o_done = done_q;

    // One radix-2 step: add b on a set bit of a, make even with N, halve.
    always_comb begin
        sum = acc_q;
        if (i_a[cnt_q[CNT_W-2:0]]) begin
            sum = sum + ACC_W'(i_b);
        end
        if (sum[0]) begin
            sum = sum + ACC_W'(i_n);
        end
        acc_next = sum >> 1;
    end

    // ==================
    // Control
    // ==================
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= MM_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                MM_IDLE: begin
                    if (i_start) begin
                        state_q <= MM_ITER;
                        cnt_q   <= '0;
                    end
                end
                MM_ITER: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(KEY_W - 1)) begin
                        state_q <= MM_CORR;
                    end
                end
                MM_CORR: begin
                    state_q <= MM_OUT;
                end
                default: begin
                    state_q <= MM_IDLE;
                    done_q  <= 1'b1;
                end
            endcase
        end
    end

    // ==================
    // Datapath
    // ==================
    always_ff @(posedge i_clk) begin
        case (state_q)
            MM_IDLE: begin
                if (i_start) begin
                    acc_q <= '0;
                end
            end
            MM_ITER: begin
                acc_q <= acc_next;
            end
            MM_CORR: begin
                // Below 2N here, so one subtraction is enough.
                if (acc_q >= ACC_W'(i_n)) begin
                    acc_q <= acc_q - ACC_W'(i_n);
                end
            end
            default: begin
                m_q <= acc_q[KEY_W-1:0];
            end
        endcase
    end

endmodule

// File: source/rsa_pkg.sv
package rsa_pkg;

    // ==================
    // Widths
    // ==================
    localparam int KEY_W     = 256;
    localparam int ACC_W     = 258;
    localparam int CNT_W     = 9;
    localparam int AXI_AW    = 12;
    localparam int AXI_DW    = 32;
    localparam int KEY_WORDS = 8;
    localparam int WIDX_W    = $clog2(KEY_WORDS);

    // ==================
    // Register map
    // ==================
    localparam logic [AXI_AW-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [AXI_AW-1:0] ADDR_STATUS = 12'h004;
    localparam logic [AXI_AW-1:0] ADDR_N      = 12'h100;
    localparam logic [AXI_AW-1:0] ADDR_E      = 12'h200;
    localparam logic [AXI_AW-1:0] ADDR_Y      = 12'h300;
    localparam logic [AXI_AW-1:0] ADDR_RES    = 12'h400;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // FSM encodings.
    localparam logic [1:0] MM_IDLE = 2'd0;
    localparam logic [1:0] MM_ITER = 2'd1;
    localparam logic [1:0] MM_CORR = 2'd2;
    localparam logic [1:0] MM_OUT  = 2'd3;

    localparam logic [1:0] PR_IDLE = 2'd0;
    localparam logic [1:0] PR_LOAD = 2'd1;
    localparam logic [1:0] PR_RUN  = 2'd2;
    localparam logic [1:0] PR_OUT  = 2'd3;

    localparam logic [1:0] EX_IDLE = 2'd0;
    localparam logic [1:0] EX_PREP = 2'd1;
    localparam logic [1:0] EX_LOOP = 2'd2;
    localparam logic [1:0] EX_FIN  = 2'd3;

    typedef struct packed {
        logic                  awvalid;
        logic [AXI_AW-1:0]     awaddr;
        logic                  wvalid;
        logic [AXI_DW-1:0]     wdata;
        logic [AXI_DW/8-1:0]   wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [AXI_AW-1:0]     araddr;
        logic                  rready;
    } axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [AXI_DW-1:0]     rdata;
        logic [1:0]            rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [KEY_W-1:0]      n;
        logic [KEY_W-1:0]      e;
        logic [KEY_W-1:0]      y;
    } rsa_job_t;

    // Decoded register address.
    typedef struct packed {
        logic                  ctrl;
        logic                  status;
        logic                  n;
        logic                  e;
        logic                  y;
        logic                  res;
        logic [WIDX_W-1:0]     idx;
    } addr_dec_t;

endpackage

// File: source/rsa_top.sv
`timescale 1ns/1ns

module rsa_top
    import rsa_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  axil_req_t i_axil,
    output axil_rsp_t o_axil
);

    rsa_job_t         job;
    logic             start;
    logic             busy;
    logic             done;
    logic [KEY_W-1:0] result;

    rsa_axil_regs u_regs (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_axil   (i_axil),
        .o_axil   (o_axil),
        .o_job    (job),
        .o_start  (start),
        .i_busy   (busy),
        .i_done   (done),
        .i_result (result)
    );

    rsa_exp_ctrl u_exp (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (start),
        .i_job    (job),
        .o_busy   (busy),
        .o_done   (done),
        .o_result (result)
    );

endmodule

// File: testbench/tb_axil_bfm.svh
`ifndef TB_AXIL_BFM_SVH
`define TB_AXIL_BFM_SVH

// Write with AW and W together; bready is held low b_hold cycles after bvalid.
task automatic send_write(
    input  logic [AXI_AW-1:0]   addr,
    input  logic [AXI_DW-1:0]   data,
    input  logic [AXI_DW/8-1:0] strb,
    input  int                  b_hold,
    output logic [1:0]          resp
);
    int   cyc;
    logic seen;
    @(negedge clk);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
        @(posedge clk);
        seen = axil_rsp.awready && axil_rsp.wready;
        cyc++;
        if (!seen && cyc > HS_TIMEOUT) begin
            abort_run("awready and wready never rose for a write");
        end
    end
    @(negedge clk);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
        @(posedge clk);
        seen = axil_rsp.bvalid;
        cyc++;
        if (!seen && cyc > HS_TIMEOUT) begin
            abort_run("bvalid never rose after a write was accepted");
        end
    end
    repeat (b_hold) begin
        @(posedge clk);
        check_word("bvalid", 32'h1, 32'(axil_rsp.bvalid));
    end
    @(negedge clk);
    axil_req.bready = 1'b1;
    @(posedge clk);
    check_word("bvalid", 32'h1, 32'(axil_rsp.bvalid));
    resp = axil_rsp.bresp;
    @(negedge clk);
    axil_req.bready = 1'b0;
endtask

// Read; rready is held low r_hold cycles and rdata must not move meanwhile.
task automatic send_read(
    input  logic [AXI_AW-1:0] addr,
    input  int                r_hold,
    output logic [AXI_DW-1:0] data,
    output logic [1:0]        resp
);
    int                cyc;
    logic              seen;
    logic [AXI_DW-1:0] held;
    @(negedge clk);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
        @(posedge clk);
        seen = axil_rsp.arready;
        cyc++;
        if (!seen && cyc > HS_TIMEOUT) begin
            abort_run("arready never rose for a read");
        end
    end
    @(negedge clk);
    axil_req.arvalid = 1'b0;
    cyc  = 0;
    seen = 1'b0;
    while (!seen) begin
        @(posedge clk);
        seen = axil_rsp.rvalid;
        cyc++;
        if (!seen && cyc > HS_TIMEOUT) begin
            abort_run("rvalid never rose after a read was accepted");
        end
    end
    held = axil_rsp.rdata;
    repeat (r_hold) begin
        @(posedge clk);
        check_word("rvalid", 32'h1, 32'(axil_rsp.rvalid));
        check_word("rdata", held, axil_rsp.rdata);
    end
    @(negedge clk);
    axil_req.rready = 1'b1;
    @(posedge clk);
    check_word("rvalid", 32'h1, 32'(axil_rsp.rvalid));
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge clk);
    axil_req.rready = 1'b0;
endtask

`endif

// File: testbench/tb_rsa_top.sv
`timescale 1ns/1ns

module tb_rsa_top
    import rsa_pkg::*;
();

    localparam int HS_TIMEOUT  = 32;
    localparam int JOB_TIMEOUT = 100000;

    logic      clk;
    logic      rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    int        mismatch_errs = 0;
    int        timeout_errs  = 0;
    longint    cycle_cnt     = 0;
    event      abort_ev;

    rsa_top u_rsa_top (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_axil (axil_req),
        .o_axil (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
            mismatch_errs++;
        end
    endtask

    task automatic report_counts();
        $display("Summary: %0d mismatches, %0d timeouts", mismatch_errs, timeout_errs);
    endtask

    // The calling process parks here; the watcher below ends the run.
    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        timeout_errs++;
        -> abort_ev;
        forever @(posedge clk);
    endtask

    initial begin
        @(abort_ev);
        report_counts();
        $display("Test failures found");
        $finish;
    end

    `include "tb_axil_bfm.svh"

    function automatic logic [AXI_AW-1:0] word_addr(input logic [AXI_AW-1:0] base, input int k);
        return base + AXI_AW'(4 * k);
    endfunction

    function automatic logic [KEY_W-1:0] rand_key();
        logic [KEY_W-1:0] v;
        for (int k = 0; k < KEY_WORDS; k++) begin
            v[k*AXI_DW +: AXI_DW] = $urandom();
        end
        return v;
    endfunction

    // Odd, full width modulus.
    function automatic logic [KEY_W-1:0] rand_modulus();
        logic [KEY_W-1:0] v;
        v          = rand_key();
        v[KEY_W-1] = 1'b1;
        v[0]       = 1'b1;
        return v;
    endfunction

    // Plain square-and-multiply, y^e mod N.
    function automatic logic [KEY_W-1:0] mod_exp(input logic [KEY_W-1:0] n, e, y);
        logic [2*KEY_W-1:0] modulus;
        logic [2*KEY_W-1:0] base;
        logic [2*KEY_W-1:0] acc;
        modulus = (2*KEY_W)'(n);
        base    = (2*KEY_W)'(y) % modulus;
        acc     = (2*KEY_W)'(1);
        for (int i = 0; i < KEY_W; i++) begin
            if (e[i]) begin
                acc = (acc * base) % modulus;
            end
            base = (base * base) % modulus;
        end
        return acc[KEY_W-1:0];
    endfunction

    task automatic write_reg(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
        logic [1:0] resp;
        send_write(addr, data, 4'hf, 0, resp);
        check_word("bresp", 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic read_reg(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data);
        logic [1:0] resp;
        send_read(addr, 0, data, resp);
        check_word("rresp", 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic start_job(input logic [KEY_W-1:0] n, e, y);
        logic [AXI_DW-1:0] rd;
        for (int k = 0; k < KEY_WORDS; k++) begin
            write_reg(word_addr(ADDR_N, k), n[k*AXI_DW +: AXI_DW]);
            write_reg(word_addr(ADDR_E, k), e[k*AXI_DW +: AXI_DW]);
            write_reg(word_addr(ADDR_Y, k), y[k*AXI_DW +: AXI_DW]);
        end
        write_reg(ADDR_CTRL, 32'h1);
        read_reg(ADDR_STATUS, rd);
        check_word("status", 32'h1, rd);
    endtask

    task automatic finish_job(input logic [KEY_W-1:0] exp_res);
        logic [AXI_DW-1:0] rd;
        longint            t0;
        t0 = cycle_cnt;
        rd = '0;
        while (!rd[1]) begin
            read_reg(ADDR_STATUS, rd);
            if (!rd[1] && cycle_cnt - t0 > JOB_TIMEOUT) begin
                abort_run("status done never rose for a job");
            end
        end
        check_word("status", 32'h2, rd);
        for (int k = 0; k < KEY_WORDS; k++) begin
            read_reg(word_addr(ADDR_RES, k), rd);
            check_word("result", exp_res[k*AXI_DW +: AXI_DW], rd);
        end
    endtask

    initial begin
        logic [KEY_W-1:0]  n;
        logic [KEY_W-1:0]  e;
        logic [KEY_W-1:0]  y;
        logic [AXI_DW-1:0] rd;
        logic [AXI_DW-1:0] word;
        logic [1:0]        resp;
        void'($urandom(25353));
        axil_req = '0;
        rst      = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // ==================
        // Reset state
        // ==================
        @(posedge clk);
        check_word("bvalid", 32'h0, 32'(axil_rsp.bvalid));
        check_word("rvalid", 32'h0, 32'(axil_rsp.rvalid));
        read_reg(ADDR_STATUS, rd);
        check_word("status", 32'h0, rd);
        for (int k = 0; k < KEY_WORDS; k++) begin
            read_reg(word_addr(ADDR_RES, k), rd);
            check_word("result", 32'h0, rd);
        end

        // ==================
        // Register readback
        // ==================
        n = rand_key();
        e = rand_key();
        y = rand_key();
        for (int k = 0; k < KEY_WORDS; k++) begin
            write_reg(word_addr(ADDR_N, k), n[k*AXI_DW +: AXI_DW]);
            write_reg(word_addr(ADDR_E, k), e[k*AXI_DW +: AXI_DW]);
            write_reg(word_addr(ADDR_Y, k), y[k*AXI_DW +: AXI_DW]);
        end
        for (int k = 0; k < KEY_WORDS; k++) begin
            read_reg(word_addr(ADDR_N, k), rd);
            check_word("n_word", n[k*AXI_DW +: AXI_DW], rd);
            read_reg(word_addr(ADDR_E, k), rd);
            check_word("e_word", e[k*AXI_DW +: AXI_DW], rd);
            read_reg(word_addr(ADDR_Y, k), rd);
            check_word("y_word", y[k*AXI_DW +: AXI_DW], rd);
        end
        // Strobe 0101 updates bytes 0 and 2 only.
        word = $urandom();
        send_write(word_addr(ADDR_N, 3), word, 4'b0101, 0, resp);
        check_word("bresp", 32'(RESP_OKAY), 32'(resp));
        read_reg(word_addr(ADDR_N, 3), rd);
        check_word("n_word", {n[127:120], word[23:16], n[111:104], word[7:0]}, rd);

        // ==================
        // Exponentiation
        // ==================
        n = rand_modulus();
        y = rand_key() % n;
        start_job(n, KEY_W'(1), y);
        finish_job(y);
        start_job(n, KEY_W'(0), y);
        finish_job(KEY_W'(1));
        repeat (8) begin
            n = rand_modulus();
            e = rand_key();
            y = rand_key() % n;
            start_job(n, e, y);
            finish_job(mod_exp(n, e, y));
        end

        // ==================
        // Protocol corners
        // ==================
        send_read(12'h800, 0, rd, resp);
        check_word("rresp", 32'(RESP_SLVERR), 32'(resp));
        check_word("rdata", 32'h0, rd);
        send_write(12'h800, $urandom(), 4'hf, 0, resp);
        check_word("bresp", 32'(RESP_SLVERR), 32'(resp));
        n = rand_modulus();
        e = rand_key();
        y = rand_key() % n;
        start_job(n, e, y);
        write_reg(word_addr(ADDR_N, 0), ~n[AXI_DW-1:0]);
        finish_job(mod_exp(n, e, y));
        read_reg(word_addr(ADDR_N, 0), rd);
        check_word("n_word", n[AXI_DW-1:0], rd);
        word = $urandom();
        send_write(word_addr(ADDR_Y, 0), word, 4'hf, 5, resp);
        check_word("bresp", 32'(RESP_OKAY), 32'(resp));
        send_read(word_addr(ADDR_Y, 0), 5, rd, resp);
        check_word("rresp", 32'(RESP_OKAY), 32'(resp));
        check_word("y_word", word, rd);

        report_counts();
        if (mismatch_errs == 0 && timeout_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
